// ==== logic/id_pkg.sv ====
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int        NUM_REGS = 32;
    localparam reg_addr_t RA_REG   = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM_SIGN, SRC2_CONST8, SRC2_IMM_ZERO} src2_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_e;

    typedef struct packed {
        logic hold_decode;
        logic hold_fetch;
    } stall_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } reg_write_t;

    typedef struct packed {
        alu_op_e   alu_op;
        src1_e     src1;
        src2_e     src2;
        logic      mem_en;
        logic      mem_we;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sel_load;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t rdata1;
        word_t rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

// ==== logic/fetch_stage_reg.sv ====
`timescale 1ns/1ps

module fetch_stage_reg (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::stall_t    stall,
    input  id_pkg::if_to_id_t if_bus,
    input  id_pkg::word_t     sram_rdata,
    output logic              cur_valid,
    output id_pkg::word_t     cur_pc,
    output id_pkg::word_t     cur_inst
);
    import id_pkg::*;

    if_to_id_t stage_q;
    logic      held;
    word_t     inst_copy;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '0;
            held    <= 1'b0;
        end else if (!stall.hold_fetch) begin
            stage_q <= if_bus;
            held    <= 1'b0;
        end else if (!stall.hold_decode) begin
            // bubble into decode
            stage_q <= '0;
            held    <= 1'b0;
        end else begin
            held <= stage_q.valid;
        end
    end

    // sram data only valid the cycle after the load, keep a copy
    always_ff @(posedge clk) begin
        if (stall.hold_fetch && stall.hold_decode && !held) begin
            inst_copy <= sram_rdata;
        end
    end

    assign cur_valid = stage_q.valid;
    assign cur_pc    = stage_q.pc;
    assign cur_inst  = held ? inst_copy : sram_rdata;

    held_implies_valid: assert property (@(posedge clk) disable iff (rst) held |-> cur_valid);

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic              valid,
    input  id_pkg::word_t     inst,
    input  id_pkg::reg_addr_t ex_load_dst,
    input  logic              ex_is_load,
    output id_pkg::ctrl_t     ctrl,
    output id_pkg::br_kind_e  br_kind,
    output logic              stallreq
);
    import id_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] sa;
    logic      reads_rs;
    logic      reads_rt;

    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];

    function automatic alu_op_e special_op(funct_e f);
        case (f)
            FN_SLL, FN_SLLV:  return ALU_SLL;
            FN_SRL, FN_SRLV:  return ALU_SRL;
            FN_SRA, FN_SRAV:  return ALU_SRA;
            FN_ADD, FN_ADDU:  return ALU_ADD;
            FN_SUB, FN_SUBU:  return ALU_SUB;
            FN_AND:           return ALU_AND;
            FN_OR:            return ALU_OR;
            FN_XOR:           return ALU_XOR;
            FN_NOR:           return ALU_NOR;
            FN_SLT:           return ALU_SLT;
            FN_SLTU:          return ALU_SLTU;
            default:          return ALU_NONE;
        endcase
    endfunction

    always_comb begin
        ctrl     = '0;
        br_kind  = BR_NONE;
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        if (valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_SLL, FN_SRL, FN_SRA: begin
                            if (rs == '0) begin
                                ctrl.alu_op   = special_op(funct);
                                ctrl.src1     = SRC1_SA;
                                ctrl.rf_we    = 1'b1;
                                ctrl.rf_waddr = rd;
                                reads_rt      = 1'b1;
                            end
                        end
                        FN_JR: begin
                            if (inst[20:6] == '0) begin
                                br_kind  = BR_JR;
                                reads_rs = 1'b1;
                            end
                        end
                        FN_JALR: begin
                            if (rt == '0 && sa == '0) begin
                                br_kind       = BR_JALR;
                                ctrl.alu_op   = ALU_ADD;
                                ctrl.src1     = SRC1_PC;
                                ctrl.src2     = SRC2_CONST8;
                                ctrl.rf_we    = 1'b1;
                                ctrl.rf_waddr = rd;
                                reads_rs      = 1'b1;
                            end
                        end
                        FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                        FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                            if (sa == '0) begin
                                ctrl.alu_op   = special_op(funct);
                                ctrl.rf_we    = 1'b1;
                                ctrl.rf_waddr = rd;
                                reads_rs      = 1'b1;
                                reads_rt      = 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
                OP_REGIMM: begin
                    if (rt == 5'd0 || rt == 5'd1) begin
                        br_kind  = (rt == 5'd0) ? BR_BLTZ : BR_BGEZ;
                        reads_rs = 1'b1;
                    end
                end
                OP_J: br_kind = BR_J;
                OP_JAL: begin
                    br_kind       = BR_JAL;
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src1     = SRC1_PC;
                    ctrl.src2     = SRC2_CONST8;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = RA_REG;
                end
                OP_BEQ, OP_BNE: begin
                    br_kind  = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                    reads_rs = 1'b1;
                    reads_rt = 1'b1;
                end
                OP_BLEZ, OP_BGTZ: begin
                    if (rt == '0) begin
                        br_kind  = (opcode == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
                        reads_rs = 1'b1;
                    end
                end
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                    ctrl.alu_op   = (opcode == OP_SLTI)  ? ALU_SLT :
                                    (opcode == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
                    ctrl.src2     = SRC2_IMM_SIGN;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rt;
                    reads_rs      = 1'b1;
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                    ctrl.alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                                    (opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
                    ctrl.src2     = SRC2_IMM_ZERO;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rt;
                    reads_rs      = 1'b1;
                end
                OP_LUI: begin
                    ctrl.alu_op   = ALU_LUI;
                    ctrl.src2     = SRC2_IMM_SIGN;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rt;
                end
                OP_LW, OP_SW: begin
                    // address is rs + offset for both
                    ctrl.alu_op = ALU_ADD;
                    ctrl.src2   = SRC2_IMM_SIGN;
                    ctrl.mem_en = 1'b1;
                    reads_rs    = 1'b1;
                    if (opcode == OP_LW) begin
                        ctrl.rf_we    = 1'b1;
                        ctrl.rf_waddr = rt;
                        ctrl.sel_load = 1'b1;
                    end else begin
                        ctrl.mem_we = 1'b1;
                        reads_rt    = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // load in execute feeding a source read here
    assign stallreq = valid && ex_is_load && (ex_load_dst != '0) &&
                      ((reads_rs && rs == ex_load_dst) || (reads_rt && rt == ex_load_dst));

    always_comb begin
        no_write_and_store: assert (!(ctrl.rf_we && ctrl.mem_we));
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  id_pkg::reg_addr_t  raddr1,
    input  id_pkg::reg_addr_t  raddr2,
    input  id_pkg::reg_write_t wb_write,
    input  id_pkg::reg_write_t ex_fwd,
    input  id_pkg::reg_write_t mem_fwd,
    output id_pkg::word_t      rdata1,
    output id_pkg::word_t      rdata2
);
    import id_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.we && wb_write.waddr != '0) begin
            regs[wb_write.waddr] <= wb_write.wdata;
        end
    end

    // youngest producer wins, wb covers the write-through case
    function automatic word_t bypass(
        input reg_addr_t  addr,
        input word_t      arr_val,
        input reg_write_t ex,
        input reg_write_t mem,
        input reg_write_t wb
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end
        if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end
        if (wb.we && wb.waddr == addr) begin
            return wb.wdata;
        end
        return arr_val;
    endfunction

    assign rdata1 = bypass(raddr1, regs[raddr1], ex_fwd, mem_fwd, wb_write);
    assign rdata2 = bypass(raddr2, regs[raddr2], ex_fwd, mem_fwd, wb_write);

    zero_reg_stays_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::br_kind_e br_kind,
    input  id_pkg::word_t    pc,
    input  id_pkg::word_t    inst,
    input  id_pkg::word_t    rs_val,
    input  id_pkg::word_t    rt_val,
    output id_pkg::branch_t  br
);
    import id_pkg::*;

    word_t pc_plus_4;
    word_t br_offset;
    word_t jump_target;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;

    assign pc_plus_4   = pc + 32'd4;
    assign br_offset   = {{14{inst[15]}}, inst[15:0], 2'b00};
    // region of the delay slot, not of the jump itself
    assign jump_target = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_eq_rt = (rs_val == rt_val);
    assign rs_neg   = rs_val[31];
    assign rs_zero  = (rs_val == '0);

    always_comb begin
        br.taken  = 1'b0;
        br.target = '0;
        case (br_kind)
            BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ: begin
                br.target = pc_plus_4 + br_offset;
                case (br_kind)
                    BR_BEQ:  br.taken = rs_eq_rt;
                    BR_BNE:  br.taken = !rs_eq_rt;
                    BR_BGEZ: br.taken = !rs_neg;
                    BR_BGTZ: br.taken = !rs_neg && !rs_zero;
                    BR_BLEZ: br.taken = rs_neg || rs_zero;
                    default: br.taken = rs_neg;
                endcase
            end
            BR_J, BR_JAL: begin
                br.taken  = 1'b1;
                br.target = jump_target;
            end
            BR_JR, BR_JALR: begin
                br.taken  = 1'b1;
                br.target = rs_val;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic               clk,
    input  logic               rst,
    input  id_pkg::stall_t     stall,
    input  id_pkg::if_to_id_t  if_bus,
    input  id_pkg::word_t      inst_sram_rdata,
    input  id_pkg::reg_write_t wb_write,
    input  id_pkg::reg_write_t ex_fwd,
    input  id_pkg::reg_write_t mem_fwd,
    input  logic               ex_is_load,
    output id_pkg::id_to_ex_t  id_to_ex,
    output id_pkg::branch_t    br_bus,
    output logic               stallreq
);
    import id_pkg::*;

    logic     cur_valid;
    word_t    cur_pc;
    word_t    cur_inst;
    ctrl_t    ctrl;
    br_kind_e br_kind;
    word_t    rdata1;
    word_t    rdata2;

    fetch_stage_reg u_stage_reg (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_bus     (if_bus),
        .sram_rdata (inst_sram_rdata),
        .cur_valid  (cur_valid),
        .cur_pc     (cur_pc),
        .cur_inst   (cur_inst)
    );

    inst_decoder u_decoder (
        .valid       (cur_valid),
        .inst        (cur_inst),
        .ex_load_dst (ex_fwd.waddr),
        .ex_is_load  (ex_is_load),
        .ctrl        (ctrl),
        .br_kind     (br_kind),
        .stallreq    (stallreq)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .raddr1   (cur_inst[25:21]),
        .raddr2   (cur_inst[20:16]),
        .wb_write (wb_write),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    branch_unit u_branch (
        .br_kind (br_kind),
        .pc      (cur_pc),
        .inst    (cur_inst),
        .rs_val  (rdata1),
        .rt_val  (rdata2),
        .br      (br_bus)
    );

    assign id_to_ex = '{
        valid:  cur_valid,
        pc:     cur_pc,
        inst:   cur_inst,
        ctrl:   ctrl,
        rdata1: rdata1,
        rdata2: rdata2
    };

endmodule

// ==== tests/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// mirror of the register array and shadow of the stage register
word_t reg_mirror [NUM_REGS];
logic  m_valid;
word_t m_pc;
int    m_hold_edges;
word_t m_inst_copy;

task automatic clear_shadow();
    for (int i = 0; i < NUM_REGS; i++) begin
        reg_mirror[i] = '0;
    end
    m_valid      = 1'b0;
    m_pc         = '0;
    m_hold_edges = 0;
    m_inst_copy  = '0;
endtask

// one rising edge, using the inputs sampled at that edge
task automatic advance_shadow();
    if (wb_write.we && wb_write.waddr != 5'd0) begin
        reg_mirror[wb_write.waddr] = wb_write.wdata;
    end
    if (!stall.hold_fetch) begin
        m_valid      = if_bus.valid;
        m_pc         = if_bus.pc;
        m_hold_edges = 0;
    end else if (!stall.hold_decode) begin
        m_valid      = 1'b0;
        m_pc         = '0;
        m_hold_edges = 0;
    end else begin
        // first hold edge freezes the instruction
        if (m_hold_edges == 0) begin
            m_inst_copy = inst_sram_rdata;
        end
        m_hold_edges++;
    end
endtask

function automatic word_t inst_in_stage();
    if (m_valid && m_hold_edges > 0) begin
        return m_inst_copy;
    end
    return inst_sram_rdata;
endfunction

function automatic word_t regfile_read(reg_addr_t addr);
    if (addr == 5'd0) begin
        return '0;
    end
    if (ex_fwd.we && ex_fwd.waddr == addr) begin
        return ex_fwd.wdata;
    end
    if (mem_fwd.we && mem_fwd.waddr == addr) begin
        return mem_fwd.wdata;
    end
    if (wb_write.we && wb_write.waddr == addr) begin
        return wb_write.wdata;
    end
    return reg_mirror[addr];
endfunction

function automatic ctrl_t alu_ctrl(alu_op_e op, src1_e s1, src2_e s2, reg_addr_t dst);
    ctrl_t c;
    c          = '0;
    c.alu_op   = op;
    c.src1     = s1;
    c.src2     = s2;
    c.rf_we    = 1'b1;
    c.rf_waddr = dst;
    return c;
endfunction

function automatic alu_op_e funct_alu(logic [5:0] fn);
    case (fn)
        FN_SLL, FN_SLLV: return ALU_SLL;
        FN_SRL, FN_SRLV: return ALU_SRL;
        FN_SRA, FN_SRAV: return ALU_SRA;
        FN_SUB, FN_SUBU: return ALU_SUB;
        FN_AND:          return ALU_AND;
        FN_OR:           return ALU_OR;
        FN_XOR:          return ALU_XOR;
        FN_NOR:          return ALU_NOR;
        FN_SLT:          return ALU_SLT;
        FN_SLTU:         return ALU_SLTU;
        default:         return ALU_ADD;
    endcase
endfunction

function automatic alu_op_e imm_alu(logic [5:0] op);
    case (op)
        OP_SLTI:  return ALU_SLT;
        OP_SLTIU: return ALU_SLTU;
        OP_ANDI:  return ALU_AND;
        OP_ORI:   return ALU_OR;
        OP_XORI:  return ALU_XOR;
        default:  return ALU_ADD;
    endcase
endfunction

function automatic void expected_decode(
    input  logic     valid,
    input  word_t    inst,
    output ctrl_t    c,
    output br_kind_e kind,
    output logic     uses_rs,
    output logic     uses_rt
);
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  f_rt;
    reg_addr_t  f_rd;
    logic       shift_imm;
    logic       reg_op;
    op        = inst[31:26];
    fn        = inst[5:0];
    f_rt      = inst[20:16];
    f_rd      = inst[15:11];
    shift_imm = fn inside {FN_SLL, FN_SRL, FN_SRA};
    reg_op    = fn inside {FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                           FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    c         = '0;
    kind      = BR_NONE;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    if (!valid) begin
        return;
    end
    if (op == OP_SPECIAL && shift_imm && inst[25:21] == 5'd0) begin
        c       = alu_ctrl(funct_alu(fn), SRC1_SA, SRC2_RT, f_rd);
        uses_rt = 1'b1;
    end else if (op == OP_SPECIAL && reg_op && inst[10:6] == 5'd0) begin
        c       = alu_ctrl(funct_alu(fn), SRC1_RS, SRC2_RT, f_rd);
        uses_rs = 1'b1;
        uses_rt = 1'b1;
    end else if (op == OP_SPECIAL && fn == FN_JR && inst[20:6] == 15'd0) begin
        kind    = BR_JR;
        uses_rs = 1'b1;
    end else if (op == OP_SPECIAL && fn == FN_JALR && f_rt == 5'd0 && inst[10:6] == 5'd0) begin
        c       = alu_ctrl(ALU_ADD, SRC1_PC, SRC2_CONST8, f_rd);
        kind    = BR_JALR;
        uses_rs = 1'b1;
    end else if (op == OP_REGIMM && f_rt <= 5'd1) begin
        kind    = f_rt[0] ? BR_BGEZ : BR_BLTZ;
        uses_rs = 1'b1;
    end else if (op == OP_J) begin
        kind = BR_J;
    end else if (op == OP_JAL) begin
        c    = alu_ctrl(ALU_ADD, SRC1_PC, SRC2_CONST8, RA_REG);
        kind = BR_JAL;
    end else if (op == OP_BEQ || op == OP_BNE) begin
        kind    = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
    end else if ((op == OP_BLEZ || op == OP_BGTZ) && f_rt == 5'd0) begin
        kind    = (op == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
        uses_rs = 1'b1;
    end else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
        c       = alu_ctrl(imm_alu(op), SRC1_RS, SRC2_IMM_SIGN, f_rt);
        uses_rs = 1'b1;
    end else if (op inside {OP_ANDI, OP_ORI, OP_XORI}) begin
        c       = alu_ctrl(imm_alu(op), SRC1_RS, SRC2_IMM_ZERO, f_rt);
        uses_rs = 1'b1;
    end else if (op == OP_LUI) begin
        c = alu_ctrl(ALU_LUI, SRC1_RS, SRC2_IMM_SIGN, f_rt);
    end else if (op == OP_LW) begin
        c          = alu_ctrl(ALU_ADD, SRC1_RS, SRC2_IMM_SIGN, f_rt);
        c.mem_en   = 1'b1;
        c.sel_load = 1'b1;
        uses_rs    = 1'b1;
    end else if (op == OP_SW) begin
        c          = alu_ctrl(ALU_ADD, SRC1_RS, SRC2_IMM_SIGN, 5'd0);
        c.rf_we    = 1'b0;
        c.mem_en   = 1'b1;
        c.mem_we   = 1'b1;
        uses_rs    = 1'b1;
        uses_rt    = 1'b1;
    end
endfunction

function automatic branch_t branch_outcome(
    br_kind_e kind,
    word_t    pc,
    word_t    inst,
    word_t    a,
    word_t    b
);
    branch_t r;
    word_t   next_pc;
    next_pc = pc + 32'd4;
    r       = '0;
    case (kind)
        BR_NONE: ;
        BR_J, BR_JAL: begin
            r.taken  = 1'b1;
            r.target = {next_pc[31:28], inst[25:0], 2'b00};
        end
        BR_JR, BR_JALR: begin
            r.taken  = 1'b1;
            r.target = a;
        end
        default: begin
            r.target = next_pc + {{14{inst[15]}}, inst[15:0], 2'b00};
            case (kind)
                BR_BEQ:  r.taken = (a == b);
                BR_BNE:  r.taken = (a != b);
                BR_BGEZ: r.taken = ($signed(a) >= 0);
                BR_BGTZ: r.taken = ($signed(a) > 0);
                BR_BLEZ: r.taken = ($signed(a) <= 0);
                default: r.taken = ($signed(a) < 0);
            endcase
        end
    endcase
    return r;
endfunction

function automatic logic load_use_stall(word_t inst, logic uses_rs, logic uses_rt);
    reg_addr_t dst;
    dst = ex_fwd.waddr;
    return m_valid && ex_is_load && dst != 5'd0 &&
           ((uses_rs && inst[25:21] == dst) || (uses_rt && inst[20:16] == dst));
endfunction

`endif

// ==== tests/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 4000;

    // instruction pools packed as six-bit fields
    localparam logic [77:0] REG_FUNCTS = {FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB,
                                          FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [17:0] SHIFT_FUNCTS = {FN_SLL, FN_SRL, FN_SRA};
    localparam logic [59:0] IMM_OPS = {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                       OP_XORI, OP_LUI, OP_LW, OP_SW};
    localparam logic [29:0] BR_OPS = {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM};

    logic        clk;
    logic        rst;
    stall_t      stall;
    if_to_id_t   if_bus;
    word_t       inst_sram_rdata;
    reg_write_t  wb_write;
    reg_write_t  ex_fwd;
    reg_write_t  mem_fwd;
    logic        ex_is_load;
    id_to_ex_t   id_to_ex;
    branch_t     br_bus;
    logic        stallreq;

    logic [31:0] lcg_state;
    int          cyc;

    `include "id_model.svh"

    id_stage uut (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_bus          (if_bus),
        .inst_sram_rdata (inst_sram_rdata),
        .wb_write        (wb_write),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .ex_is_load      (ex_is_load),
        .id_to_ex        (id_to_ex),
        .br_bus          (br_bus),
        .stallreq        (stallreq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // fold high bits down since the low LCG bits repeat quickly
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic int rand_below(int n);
        word_t r;
        r = lcg_next();
        return int'(r % n);
    endfunction

    // small indices most of the time so forwards and hazards collide
    function automatic reg_addr_t reg_index();
        if (rand_below(4) == 0) begin
            return 5'(rand_below(32));
        end
        return 5'(rand_below(8));
    endfunction

    function automatic word_t pick_inst();
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        reg_addr_t  shift_rs;
        logic [4:0] sa;
        logic [5:0] op;
        word_t      tail;
        int         pick;
        rs       = reg_index();
        rt       = reg_index();
        rd       = reg_index();
        shift_rs = (rand_below(8) == 0) ? rs : 5'd0;
        sa       = (rand_below(8) == 0) ? 5'(rand_below(32)) : 5'd0;
        tail     = lcg_next();
        pick     = rand_below(13);
        case (rand_below(8))
            0, 1: return {OP_SPECIAL, rs, rt, rd, sa, REG_FUNCTS[6 * pick +: 6]};
            2: return {OP_SPECIAL, shift_rs, rt, rd, tail[10:6], SHIFT_FUNCTS[6 * (pick % 3) +: 6]};
            3, 4: return {IMM_OPS[6 * (pick % 10) +: 6], rs, rt, tail[15:0]};
            5: begin
                op = BR_OPS[6 * (pick % 5) +: 6];
                if (op == OP_REGIMM) begin
                    rt = {4'd0, tail[16]};
                end else if (op != OP_BEQ && op != OP_BNE) begin
                    rt = 5'd0;
                end
                return {op, rs, rt, tail[15:0]};
            end
            6: begin
                case (pick % 4)
                    0: return {OP_J, tail[25:0]};
                    1: return {OP_JAL, tail[25:0]};
                    2: return {OP_SPECIAL, rs, 15'd0, FN_JR};
                    default: return {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
                endcase
            end
            default: return tail;
        endcase
    endfunction

    function automatic reg_write_t random_write(int pct);
        reg_write_t w;
        w.we    = (rand_below(100) < pct);
        w.waddr = reg_index();
        w.wdata = lcg_next();
        return w;
    endfunction

    task automatic drive_inputs();
        stall_t    s;
        if_to_id_t f;
        word_t     r;
        r             = lcg_next();
        s.hold_fetch  = (r[3:0] < 4'd5);
        s.hold_decode = r[4] | r[5];
        f.valid       = (r[7:6] != 2'b00);
        f.pc          = lcg_next() & 32'hffff_fffc;
        stall           <= s;
        if_bus          <= f;
        ex_is_load      <= r[9];
        inst_sram_rdata <= pick_inst();
        wb_write        <= random_write(60);
        ex_fwd          <= random_write(30);
        mem_fwd         <= random_write(30);
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s at cycle %0d: expected %b, actual %b", name, cyc, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
            abort_run();
        end
    endtask

    task automatic verify_ctrl(string name, ctrl_t exp, ctrl_t act);
        if (act !== exp) begin
            $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
            abort_run();
        end
    endtask

    task automatic check_branch(string name, branch_t exp, branch_t act);
        if (act !== exp) begin
            $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
            abort_run();
        end
    endtask

    task automatic sample_and_check();
        word_t    inst;
        ctrl_t    exp_ctrl;
        br_kind_e kind;
        logic     uses_rs;
        logic     uses_rt;
        word_t    rs_val;
        word_t    rt_val;
        inst   = inst_in_stage();
        expected_decode(m_valid, inst, exp_ctrl, kind, uses_rs, uses_rt);
        rs_val = regfile_read(inst[25:21]);
        rt_val = regfile_read(inst[20:16]);
        expect_bit("valid", m_valid, id_to_ex.valid);
        compare_word("pc", m_pc, id_to_ex.pc);
        compare_word("inst", inst, id_to_ex.inst);
        verify_ctrl("ctrl", exp_ctrl, id_to_ex.ctrl);
        compare_word("rdata1", rs_val, id_to_ex.rdata1);
        compare_word("rdata2", rt_val, id_to_ex.rdata2);
        check_branch("branch", branch_outcome(kind, m_pc, inst, rs_val, rt_val), br_bus);
        expect_bit("stallreq", load_use_stall(inst, uses_rs, uses_rt), stallreq);
    endtask

    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD);
        $display("timeout: the test loop did not finish in the expected time");
        abort_run();
    end

    initial begin
        lcg_state       = 32'h6c31_d7bd;
        clk             = 1'b0;
        rst             = 1'b1;
        stall           = '0;
        if_bus          = '0;
        inst_sram_rdata = '0;
        wb_write        = '0;
        ex_fwd          = '0;
        mem_fwd         = '0;
        ex_is_load      = 1'b0;
        clear_shadow();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs();
            @(negedge clk);
            sample_and_check();
            @(posedge clk);
            advance_shadow();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+tests
logic/id_pkg.sv
logic/fetch_stage_reg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/branch_unit.sv
logic/id_stage.sv
tests/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_id_stage \
    -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_id_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
